/* shift_unit.f */
+incdir+src
src/shift_unit_pkg.sv
src/shift_left_pipe.sv
src/shift_right_pipe.sv
src/shift_merge.sv
src/shift_unit.sv
bench/shift_unit_checker.sv
bench/shift_unit_asserts.sv
bench/shift_unit_tb.sv

/* Makefile */
# Verilator build and run for the shift unit testbench

VERILATOR ?= verilator
TOP       ?= shift_unit_tb
FILELIST  ?= shift_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= test failed
PASS_MSG  ?= test passed

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard src/*.sv src/*.svh bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a verdict, see $(LOG)"; exit 1; \
	else \
		echo "simulation PASSED"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/shift_unit_tb.sv */
// Testbench top for the shift unit, drives LCG stimulus through five cases and prints the verdict
`timescale 1ns/1ps
`include "shift_unit_macros.svh"

module shift_unit_tb;

    localparam int TIMEOUT = 200;

    logic                       clk;
    logic                       rst_n;
    shift_unit_pkg::shift_req_t req_i;
    logic                       valid_i;
    logic                       ready_o;
    logic [`SHU_DATA_W-1:0]     data_o;
    logic                       valid_o;
    logic                       ready_i;

    logic [31:0] rng_state;
    logic        rand_ready;
    logic        ready_seen;
    logic        timed_out;
    int          tb_errors;
    int          sent;
    int          checked;
    int          chk_errors;
    int          pending;
    int          total_errors;

    always #10 clk = ~clk;

    shift_unit u_shift_unit (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_i   (req_i),
        .valid_i (valid_i),
        .ready_o (ready_o),
        .data_o  (data_o),
        .valid_o (valid_o),
        .ready_i (ready_i)
    );

    shift_unit_checker u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_i       (req_i),
        .in_valid_i  (valid_i),
        .in_ready_i  (ready_o),
        .out_data_i  (data_o),
        .out_valid_i (valid_o),
        .out_ready_i (ready_i),
        .checked_o   (checked),
        .errors_o    (chk_errors),
        .pending_o   (pending)
    );

    // Upper half of the state has the longest bit periods
    function automatic logic [15:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state[31:16];
    endfunction

    // Inputs change 1 ns after the rising edge
    task automatic step_cycle();
        logic [15:0] r;
        @(posedge clk);
        // The handshake is judged by ready_o as it stands at the edge
        ready_seen = ready_o;
        #1;
        if (rand_ready) begin
            r = lcg_next();
            ready_i = r[0];
        end
    endtask

    task automatic note_timeout(input string what);
        $display("Timeout at %0t while waiting for %s", $time, what);
        timed_out = 1'b1;
    endtask

    // Returns just after the accepting edge with valid_i still high
    task automatic send_req(input shift_unit_pkg::shift_op_e op,
                            input logic [`SHU_AMT_W-1:0] amt, input logic [15:0] data);
        int n;
        if (timed_out) return;
        req_i.op   = op;
        req_i.amt  = amt;
        req_i.data = data;
        valid_i    = 1'b1;
        n = 0;
        step_cycle();
        while (!ready_seen && n < TIMEOUT) begin
            step_cycle();
            n++;
        end
        if (!ready_seen) begin
            note_timeout("ready_o");
        end else begin
            sent++;
        end
    endtask

    task automatic wait_drain();
        int n;
        valid_i = 1'b0;
        if (timed_out) return;
        n = 0;
        while (pending != 0 && n < TIMEOUT) begin
            step_cycle();
            n++;
        end
        if (pending != 0) begin
            note_timeout("the outstanding results");
        end
    endtask

    task automatic report_case(input int num, input string name);
        $display("case %0d (%s) finished: %0d results checked, %0d errors so far",
                 num, name, checked, tb_errors + chk_errors);
    endtask

    initial begin
        logic [15:0] word;
        logic [15:0] r;
        int          n;
        clk        = 1'b0;
        rst_n      = 1'b0;
        req_i      = '0;
        valid_i    = 1'b0;
        ready_i    = 1'b1;
        rng_state  = 32'd3;
        rand_ready = 1'b0;
        timed_out  = 1'b0;
        tb_errors  = 0;
        sent       = 0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        if (valid_o !== 1'b0 || ready_o !== 1'b1) begin
            $display("FAIL %0t: after reset valid_o=%b ready_o=%b, expected 0 and 1",
                     $time, valid_o, ready_o);
            tb_errors++;
        end
        send_req(shift_unit_pkg::SHIFT_SHL, 4'd5, lcg_next());
        valid_i = 1'b0;
        n = 0;
        while (!valid_o && n < TIMEOUT) begin
            step_cycle();
            n++;
        end
        if (!valid_o) begin
            note_timeout("the first result");
        end else if (n + 1 != 6) begin
            $display("FAIL %0t: result taken %0d edges after acceptance, expected 6",
                     $time, n + 1);
            tb_errors++;
        end
        wait_drain();
        report_case(1, "reset and latency");

        for (int i = 0; i < 200; i++) begin
            r = lcg_next();
            send_req(r[0] ? shift_unit_pkg::SHIFT_SHR : shift_unit_pkg::SHIFT_SHL,
                     i[3:0], lcg_next());
        end
        wait_drain();
        report_case(2, "logical shifts");

        // Top bit forced to 1 for the first sixteen, then to 0
        for (int i = 0; i < 32; i++) begin
            word = lcg_next();
            word[15] = (i < 16);
            send_req(shift_unit_pkg::SHIFT_SRA, i[3:0], word);
        end
        wait_drain();
        report_case(3, "arithmetic right");

        for (int i = 0; i < 48; i++) begin
            send_req(shift_unit_pkg::SHIFT_ROL, i[3:0], lcg_next());
        end
        wait_drain();
        report_case(4, "rotate left");

        rand_ready = 1'b1;
        for (int i = 0; i < 300; i++) begin
            r = lcg_next();
            if (r[9:8] == 2'd0) begin
                valid_i = 1'b0;
                step_cycle();
            end
            send_req(shift_unit_pkg::shift_op_e'(r[1:0]), r[5:2], lcg_next());
        end
        wait_drain();
        rand_ready = 1'b0;
        ready_i    = 1'b1;
        if (checked != sent) begin
            $display("FAIL %0t: %0d results for %0d accepted requests", $time, checked, sent);
            tb_errors++;
        end
        report_case(5, "mixed stream with back-pressure");

        total_errors = tb_errors + chk_errors + u_shift_unit.u_shift_unit_asserts.fail_count;
        $display("%0d requests sent, %0d results checked, %0d errors, timeout %0s",
                 sent, checked, total_errors, timed_out ? "yes" : "no");
        if (total_errors == 0 && !timed_out) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* bench/shift_unit_asserts.sv */
// Handshake and reset properties of the shift unit, attached to the top level by bind
`timescale 1ns/1ps
`include "shift_unit_macros.svh"

module shift_unit_asserts (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   in_ready_i,
    input logic [`SHU_DATA_W-1:0] out_data_i,
    input logic                   out_valid_i,
    input logic                   out_ready_i
);

    int fail_count = 0;

    // No result is offered while reset is held
    valid_low_in_reset: assert property (@(posedge clk) !rst_n |-> !out_valid_i)
    else begin
        $error("valid_o high during reset");
        fail_count++;
    end

    // A stalled result holds its word until taken
    data_held_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid_i && !out_ready_i) |=> (out_valid_i && $stable(out_data_i)))
    else begin
        $error("data_o or valid_o changed while stalled");
        fail_count++;
    end

    ready_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> in_ready_i)
    else begin
        $error("ready_o low in the first cycle after reset");
        fail_count++;
    end

endmodule

bind shift_unit shift_unit_asserts u_shift_unit_asserts (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_ready_i  (ready_o),
    .out_data_i  (data_o),
    .out_valid_i (valid_o),
    .out_ready_i (ready_i)
);

/* bench/shift_unit_checker.sv */
// Scoreboard for the shift unit, models each accepted request and compares results in order
`timescale 1ns/1ps
`include "shift_unit_macros.svh"

module shift_unit_checker (
    input  logic                       clk,
    input  logic                       rst_n,
    input  shift_unit_pkg::shift_req_t req_i,
    input  logic                       in_valid_i,
    input  logic                       in_ready_i,
    input  logic [`SHU_DATA_W-1:0]     out_data_i,
    input  logic                       out_valid_i,
    input  logic                       out_ready_i,
    output int                         checked_o,
    output int                         errors_o,
    output int                         pending_o
);

    logic [`SHU_DATA_W-1:0] exp_q [$];

    // Expected word straight from the operation definitions
    function automatic logic [`SHU_DATA_W-1:0] expected_word(input shift_unit_pkg::shift_req_t r);
        logic [`SHU_DATA_W-1:0] res;
        case (r.op)
            shift_unit_pkg::SHIFT_SHL: res = r.data << r.amt;
            shift_unit_pkg::SHIFT_SHR: res = r.data >> r.amt;
            shift_unit_pkg::SHIFT_SRA: res = $signed(r.data) >>> r.amt;
            default: begin
                // Rotate taken as a window of the word written twice
                res = `SHU_DATA_W'({r.data, r.data} >> (`SHU_DATA_W - int'(r.amt)));
            end
        endcase
        return res;
    endfunction

    initial begin
        checked_o = 0;
        errors_o  = 0;
        pending_o = 0;
    end

    always @(posedge clk or negedge rst_n) begin
        logic [`SHU_DATA_W-1:0] exp_word;
        if (!rst_n) begin
            exp_q.delete();
            pending_o = 0;
        end else begin
            if (out_valid_i && out_ready_i) begin
                if (exp_q.size() == 0) begin
                    $display("At %0t a result came out with no request outstanding", $time);
                    errors_o++;
                end else begin
                    exp_word = exp_q.pop_front();
                    checked_o++;
                    if (out_data_i !== exp_word) begin
                        $display("FAIL %0t: data_o is %h, expected %h", $time, out_data_i,
                                 exp_word);
                        errors_o++;
                    end
                end
            end
            if (in_valid_i && in_ready_i) begin
                exp_q.push_back(expected_word(req_i));
                // Five pipe stages plus the merge register is all the unit can hold
                if (exp_q.size() > `SHU_DEPTH + 1) begin
                    $display("At %0t more requests are outstanding than the unit can hold",
                             $time);
                    errors_o++;
                end
            end
            pending_o = exp_q.size();
        end
    end

endmodule

/* src/shift_unit.sv */
// Top of the pipelined shift unit, feeding both shifter pipes and joining them at the merge stage
`timescale 1ns/1ps
`include "shift_unit_macros.svh"

module shift_unit (
    input  logic                       clk,
    input  logic                       rst_n,
    input  shift_unit_pkg::shift_req_t req_i,
    input  logic                       valid_i,
    output logic                       ready_o,
    output logic [`SHU_DATA_W-1:0]     data_o,
    output logic                       valid_o,
    input  logic                       ready_i
);

    logic [`SHU_DATA_W-1:0]     left_data;
    logic [`SHU_DATA_W-1:0]     right_data;
    shift_unit_pkg::shift_tag_t left_tag;
    logic                       left_valid;
    logic                       left_ready;
    logic                       right_ready;
    logic                       merge_ready;

    // Both pipes see the same valid and ready, so their readies agree
    assign ready_o = left_ready && right_ready;

    shift_left_pipe u_left (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_i   (req_i),
        .valid_i (valid_i),
        .ready_o (left_ready),
        .data_o  (left_data),
        .tag_o   (left_tag),
        .valid_o (left_valid),
        .ready_i (merge_ready)
    );

    // Its valid tracks the left pipe cycle for cycle
    shift_right_pipe u_right (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_i   (req_i),
        .valid_i (valid_i),
        .ready_o (right_ready),
        .data_o  (right_data),
        .valid_o (),
        .ready_i (merge_ready)
    );

    shift_merge u_merge (
        .clk          (clk),
        .rst_n        (rst_n),
        .left_data_i  (left_data),
        .left_tag_i   (left_tag),
        .right_data_i (right_data),
        .valid_i      (left_valid),
        .ready_o      (merge_ready),
        .data_o       (data_o),
        .valid_o      (valid_o),
        .ready_i      (ready_i)
    );

endmodule

/* src/shift_merge.sv */
// Output stage that picks or combines the two shifter results by operation and registers them
`timescale 1ns/1ps
`include "shift_unit_macros.svh"

module shift_merge (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`SHU_DATA_W-1:0]     left_data_i,
    input  shift_unit_pkg::shift_tag_t left_tag_i,
    input  logic [`SHU_DATA_W-1:0]     right_data_i,
    input  logic                       valid_i,
    output logic                       ready_o,
    output logic [`SHU_DATA_W-1:0]     data_o,
    output logic                       valid_o,
    input  logic                       ready_i
);

    logic [`SHU_DATA_W-1:0] merged;

    always_comb begin
        merged = left_data_i;
        case (left_tag_i.op)
            shift_unit_pkg::SHIFT_SHR,
            shift_unit_pkg::SHIFT_SRA: begin
                merged = right_data_i;
            end
            shift_unit_pkg::SHIFT_ROL: begin
                // Bits that wrapped around come from the right pipe
                merged = left_data_i | (left_tag_i.amt_zero ? '0 : right_data_i);
            end
            default: begin
                merged = left_data_i;
            end
        endcase
    end

    // Output register takes a new word when empty or when the current one is consumed
    assign ready_o = ready_i || !valid_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
        end else if (ready_o) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (ready_o && valid_i) begin
            data_o <= merged;
        end
    end

endmodule

/* src/shift_right_pipe.sv */
// Five-register right barrel shifter with a fill bit, deriving its own amount from the request
`timescale 1ns/1ps
`include "shift_unit_macros.svh"

module shift_right_pipe (
    input  logic                       clk,
    input  logic                       rst_n,
    input  shift_unit_pkg::shift_req_t req_i,
    input  logic                       valid_i,
    output logic                       ready_o,
    output logic [`SHU_DATA_W-1:0]     data_o,
    output logic                       valid_o,
    input  logic                       ready_i
);

    localparam int DW = `SHU_DATA_W;
    localparam int AW = `SHU_AMT_W;

    logic [`SHU_DEPTH-1:0] stg_valid;
    logic [`SHU_DEPTH-1:0] stg_ready;
    logic [DW-1:0]         stg_data [`SHU_DEPTH];
    logic [AW-1:0]         stg_amt  [`SHU_DEPTH-1];
    logic                  stg_fill [`SHU_DEPTH-1];

    logic [AW-1:0]         right_amt;
    logic                  fill_bit;

    // Rotate needs the complementary amount, modulo the word width
    always_comb begin
        if (req_i.op == shift_unit_pkg::SHIFT_ROL) begin
            right_amt = AW'(DW - int'(req_i.amt));
        end else begin
            right_amt = req_i.amt;
        end
        fill_bit = (req_i.op == shift_unit_pkg::SHIFT_SRA) ? req_i.data[DW-1] : 1'b0;
    end

    // Same back-pressure rule as the left pipe, so both stay in lockstep
    always_comb begin
        for (int i = 0; i < `SHU_DEPTH; i++) begin
            stg_ready[i] = ready_i || ((~stg_valid >> i) != '0);
        end
    end

    assign ready_o = stg_ready[0];
    assign data_o  = stg_data[`SHU_DEPTH-1];
    assign valid_o = stg_valid[`SHU_DEPTH-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stg_valid <= '0;
        end else begin
            if (stg_ready[0]) begin
                stg_valid[0] <= valid_i;
            end
            for (int i = 1; i < `SHU_DEPTH; i++) begin
                if (stg_ready[i]) begin
                    stg_valid[i] <= stg_valid[i-1];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (stg_ready[0] && valid_i) begin
            stg_data[0] <= req_i.data;
            stg_amt[0]  <= right_amt;
            stg_fill[0] <= fill_bit;
        end
        // Fill bit is placed above the word so the signed shift brings it in from the top
        for (int i = 1; i < `SHU_DEPTH; i++) begin
            if (stg_ready[i] && stg_valid[i-1]) begin
                stg_data[i] <= stg_amt[i-1][i-1]
                             ? DW'($signed({stg_fill[i-1], stg_data[i-1]}) >>> (1 << (i - 1)))
                             : stg_data[i-1];
            end
        end
        for (int i = 1; i < `SHU_DEPTH-1; i++) begin
            if (stg_ready[i] && stg_valid[i-1]) begin
                stg_amt[i]  <= stg_amt[i-1];
                stg_fill[i] <= stg_fill[i-1];
            end
        end
    end

endmodule

/* src/shift_left_pipe.sv */
// Five-register left barrel shifter with valid/ready back-pressure, carrying the operation tag
`timescale 1ns/1ps
`include "shift_unit_macros.svh"

module shift_left_pipe (
    input  logic                       clk,
    input  logic                       rst_n,
    input  shift_unit_pkg::shift_req_t req_i,
    input  logic                       valid_i,
    output logic                       ready_o,
    output logic [`SHU_DATA_W-1:0]     data_o,
    output shift_unit_pkg::shift_tag_t tag_o,
    output logic                       valid_o,
    input  logic                       ready_i
);

    logic [`SHU_DEPTH-1:0]      stg_valid;
    logic [`SHU_DEPTH-1:0]      stg_ready;
    logic [`SHU_DATA_W-1:0]     stg_data [`SHU_DEPTH];
    // The last stage needs no amount, so it is kept for stages 0 to 3 only
    logic [`SHU_AMT_W-1:0]      stg_amt  [`SHU_DEPTH-1];
    shift_unit_pkg::shift_tag_t stg_tag  [`SHU_DEPTH];

    // A stage may load when the output drains or any stage from it onward is empty
    always_comb begin
        for (int i = 0; i < `SHU_DEPTH; i++) begin
            stg_ready[i] = ready_i || ((~stg_valid >> i) != '0);
        end
    end

    assign ready_o = stg_ready[0];
    assign data_o  = stg_data[`SHU_DEPTH-1];
    assign tag_o   = stg_tag[`SHU_DEPTH-1];
    assign valid_o = stg_valid[`SHU_DEPTH-1];

    // Occupancy of each stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stg_valid <= '0;
        end else begin
            if (stg_ready[0]) begin
                stg_valid[0] <= valid_i;
            end
            for (int i = 1; i < `SHU_DEPTH; i++) begin
                if (stg_ready[i]) begin
                    stg_valid[i] <= stg_valid[i-1];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        // Stage 0 captures the request and forms the tag
        if (stg_ready[0] && valid_i) begin
            stg_data[0]         <= req_i.data;
            stg_amt[0]          <= req_i.amt;
            stg_tag[0].op       <= req_i.op;
            stg_tag[0].amt_zero <= (req_i.amt == '0);
        end
        // Stage i shifts by 2**(i-1) under amount bit i-1, zeros enter at the bottom
        for (int i = 1; i < `SHU_DEPTH; i++) begin
            if (stg_ready[i] && stg_valid[i-1]) begin
                stg_data[i] <= stg_amt[i-1][i-1] ? stg_data[i-1] << (1 << (i - 1))
                                                 : stg_data[i-1];
                stg_tag[i]  <= stg_tag[i-1];
            end
        end
        for (int i = 1; i < `SHU_DEPTH-1; i++) begin
            if (stg_ready[i] && stg_valid[i-1]) begin
                stg_amt[i] <= stg_amt[i-1];
            end
        end
    end

endmodule

/* src/shift_unit_pkg.sv */
// Shared types of the shift unit, referenced by scoped names from the RTL and the testbench
`include "shift_unit_macros.svh"

package shift_unit_pkg;

    // Shift operation carried with every request
    typedef enum logic [1:0] {
        SHIFT_SHL = 2'd0,
        SHIFT_SHR = 2'd1,
        SHIFT_SRA = 2'd2,
        SHIFT_ROL = 2'd3
    } shift_op_e;

    // Request word presented on the input handshake
    typedef struct packed {
        shift_op_e              op;
        logic [`SHU_AMT_W-1:0]  amt;
        logic [`SHU_DATA_W-1:0] data;
    } shift_req_t;

    // Side information that rides the left pipe to the merge stage
    typedef struct packed {
        shift_op_e op;
        // Set when the requested amount was zero
        logic      amt_zero;
    } shift_tag_t;

endpackage

/* src/shift_unit_macros.svh */
// Width and depth constants for the shift unit, included by the package and every RTL module
`ifndef SHIFT_UNIT_MACROS_SVH
`define SHIFT_UNIT_MACROS_SVH

// Data word width in bits
`define SHU_DATA_W 16

// Shift amount width, enough to cover 0 to SHU_DATA_W-1
`define SHU_AMT_W 4

// Register stages in each shift pipe, one load stage plus one per amount bit
`define SHU_DEPTH 5

`endif
